//--- dv/fc_init_props.sv
// stream handshake and reset assertions for the output skid buffer
`timescale 1ns/1ps

module fc_init_props (
  input logic                    clk_i,
  input logic                    rst_i,
  input fc_init_pkg::axis_beat_t s_beat_i,
  input logic                    s_valid_i,
  input logic                    s_ready_i,
  input fc_init_pkg::axis_beat_t m_beat_i,
  input logic                    m_valid_i,
  input logic                    m_ready_i
);

  // stalled output beat holds until taken
  m_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_beat_i))
    else $error("output beat dropped or changed while stalled");

  // controller side follows the same rule
  s_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    s_valid_i && !s_ready_i |=> s_valid_i && $stable(s_beat_i))
    else $error("input beat dropped or changed while stalled");

  m_reset_a : assert property (@(posedge clk_i) rst_i |=> !m_valid_i)
    else $error("output valid high after a reset cycle");

endmodule

//--- dv/fc_init_tb.sv
// testbench for the VC0 flow control init transmitter with a beat level reference model
`timescale 1ns/1ps
`include "fc_init_defines.svh"

module fc_init_tb;
  import fc_init_pkg::*;

  localparam int        max_wait     = 20000;
  localparam int        quiet_cycles = 40;
  localparam wait_cnt_t test_wait    = 16'd8;

  logic         clk_i;
  logic         gen_rst;
  logic         tb_rst;
  logic         rst_i;
  logic         start_i;
  logic         fc1_stored_i;
  logic         fc2_stored_i;
  logic         cfg_we_i;
  logic [2:0]   cfg_addr_i;
  logic [15:0]  cfg_wdata_i;
  logic         m_tready_i;
  axis_beat_t   m_beat_o;
  logic         m_tvalid_o;
  logic         init_ack_o;
  logic         fc2_sent_o;

  hdr_credit_t  model_hdr [3];
  data_credit_t model_data [3];
  axis_beat_t   got_q [$];
  axis_beat_t   exp_q [$];
  int           ack_count = 0;
  logic [31:0]  lcg_state;
  int           err_count;
  int           test_count;
  int           fail_count;
  logic         timed_out;

  assign rst_i = gen_rst | tb_rst;

  tb_clk_gen clk_gen_i (
    .clk_o (clk_i),
    .rst_o (gen_rst)
  );

  fc_init_top dut_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .fc1_stored_i (fc1_stored_i),
    .fc2_stored_i (fc2_stored_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .m_tready_i   (m_tready_i),
    .m_beat_o     (m_beat_o),
    .m_tvalid_o   (m_tvalid_o),
    .init_ack_o   (init_ack_o),
    .fc2_sent_o   (fc2_sent_o)
  );

  bind axis_skid_buffer fc_init_props props_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_beat_i  (s_beat_i),
    .s_valid_i (s_valid_i),
    .s_ready_i (s_ready_o),
    .m_beat_i  (m_beat_o),
    .m_valid_i (m_valid_o),
    .m_ready_i (m_ready_i)
  );

  // handshake is stable mid-cycle, so transfers are taken there
  always @(negedge clk_i) begin
    if (!rst_i && m_tvalid_o && m_tready_i) begin
      got_q.push_back(m_beat_o);
    end
    if (!rst_i && init_ack_o) begin
      ack_count++;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:8]) % n;
  endfunction

  function automatic logic [7:0] bit_reverse8(input logic [7:0] v);
    logic [7:0] r;
    for (int j = 0; j < 8; j++) begin
      r[j] = v[7-j];
    end
    return r;
  endfunction

  // poly 100B, seed FFFF, type byte first, inverted, each byte sent lsb first
  function automatic dllp_crc_t model_crc(input dllp_fc_t body);
    logic [31:0] bits;
    logic [15:0] lfsr;
    logic [7:0]  octet;
    logic        msb;
    bits = body;
    lfsr = 16'hFFFF;
    for (int b = 3; b >= 0; b--) begin
      octet = bits[8*b +: 8];
      for (int k = 7; k >= 0; k--) begin
        msb  = lfsr[15] ^ octet[k];
        lfsr = lfsr << 1;
        if (msb) begin
          lfsr = lfsr ^ 16'h100B;
        end
      end
    end
    lfsr = ~lfsr;
    return {bit_reverse8(lfsr[15:8]), bit_reverse8(lfsr[7:0])};
  endfunction

  function automatic dllp_fc_t model_body(input logic fc2, input int idx);
    logic [7:0] code;
    case (idx)
      0: code = 8'h40;
      1: code = 8'h50;
      default: code = 8'h60;
    endcase
    // InitFC2 codes only differ in the top bit
    if (fc2) begin
      code[7] = 1'b1;
    end
    return dllp_fc_t'({code, 2'b00, model_hdr[idx], 2'b00, model_data[idx]});
  endfunction

  task automatic push_dllp(input logic fc2, input int idx);
    dllp_fc_t   body;
    axis_beat_t beat;
    body       = model_body(fc2, idx);
    beat.tdata = body;
    beat.tkeep = 4'hF;
    beat.tlast = 1'b0;
    exp_q.push_back(beat);
    beat.tdata = {16'h0000, model_crc(body)};
    beat.tkeep = 4'h3;
    beat.tlast = 1'b1;
    exp_q.push_back(beat);
  endtask

  task automatic check_body(input string name, input dllp_fc_t got, input dllp_fc_t want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic check_crc(input string name, input dllp_crc_t got, input dllp_crc_t want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic check_keep(input string name, input logic [`FC_KEEP_WIDTH-1:0] got,
                            input logic [`FC_KEEP_WIDTH-1:0] want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic compare_beat(input axis_beat_t got, input axis_beat_t want);
    if (want.tlast) begin
      check_crc("crc_beat.tdata[15:0]", got.tdata[15:0], want.tdata[15:0]);
      check_crc("crc_beat.tdata[31:16]", got.tdata[31:16], 16'h0000);
    end else begin
      check_body("body_beat.tdata", got.tdata, want.tdata);
    end
    check_keep("tkeep", got.tkeep, want.tkeep);
    check_flag("tlast", got.tlast, want.tlast);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic cfg_write(input logic [2:0] addr, input logic [15:0] data);
    int idx;
    next_cycle();
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    next_cycle();
    cfg_we_i = 1'b0;
    idx      = int'(addr) / 2;
    if (idx < 3 && addr[0]) begin
      model_data[idx] = data[11:0];
    end else if (idx < 3) begin
      model_hdr[idx] = data[7:0];
    end
  endtask

  task automatic do_reset();
    next_cycle();
    tb_rst       = 1'b1;
    start_i      = 1'b0;
    fc1_stored_i = 1'b0;
    fc2_stored_i = 1'b0;
    cfg_we_i     = 1'b0;
    m_tready_i   = 1'b1;
    repeat (4) next_cycle();
    tb_rst = 1'b0;
    for (int i = 0; i < 3; i++) begin
      model_hdr[i]  = `FC_HDR_RESET;
      model_data[i] = `FC_DATA_RESET;
    end
    next_cycle();
    check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
    check_flag("init_ack_o", init_ack_o, 1'b0);
    check_flag("fc2_sent_o", fc2_sent_o, 1'b0);
    check_flag("busy_o", dut_i.u_ctrl.busy_o, 1'b0);
    cfg_write(3'd6, test_wait);
  endtask

  task automatic randomize_credits();
    logic [31:0] r;
    for (int a = 0; a < 6; a++) begin
      r = lcg_next();
      cfg_write(3'(a), r[15:0]);
    end
  endtask

  // stored inputs are withheld for all but the last round of each phase
  task automatic run_sequence(input int fc1_rounds, input int fc2_rounds,
                              input logic bp, input logic write_busy);
    int          base;
    int          ack_base;
    int          seen;
    int          trig1;
    int          trig2;
    int          delay1;
    int          delay2;
    int          wr_idx;
    int          cycles;
    logic        done;
    logic [31:0] r;
    exp_q.delete();
    for (int n = 0; n < fc1_rounds * 3; n++) begin
      push_dllp(1'b0, n % 3);
    end
    for (int n = 0; n < fc2_rounds * 3; n++) begin
      push_dllp(1'b1, n % 3);
    end
    base     = got_q.size();
    ack_base = ack_count;
    trig1    = 6 * (fc1_rounds - 1) + 1;
    trig2    = 6 * (fc1_rounds + fc2_rounds - 1) + 1;
    delay1   = rand_below(8);
    delay2   = rand_below(8);
    wr_idx   = 0;
    cycles   = 0;
    done     = 1'b0;
    start_i  = 1'b1;
    while (!done && cycles < max_wait && !timed_out) begin
      next_cycle();
      cycles++;
      done = fc2_sent_o;
      if (!fc2_stored_i) begin
        check_flag("fc2_sent_o", fc2_sent_o, 1'b0);
      end
      seen       = got_q.size() - base;
      m_tready_i = bp ? (rand_below(10) < 7) : 1'b1;
      if (seen >= trig1 && !fc1_stored_i) begin
        if (delay1 == 0) begin
          fc1_stored_i = 1'b1;
        end else begin
          delay1--;
        end
      end
      if (seen >= trig2 && !fc2_stored_i) begin
        if (delay2 == 0) begin
          fc2_stored_i = 1'b1;
        end else begin
          delay2--;
        end
      end
      cfg_we_i = 1'b0;
      if (write_busy && seen >= 1 && wr_idx < 7) begin
        r           = lcg_next();
        cfg_we_i    = 1'b1;
        cfg_addr_i  = 3'(wr_idx);
        cfg_wdata_i = r[15:0];
        wr_idx++;
      end
    end
    cfg_we_i = 1'b0;
    if (!done && !timed_out) begin
      $display("timeout: fc2_sent_o still low after %0d cycles", max_wait);
      err_count++;
      timed_out = 1'b1;
    end
    // nothing may leave once complete
    m_tready_i = 1'b1;
    for (int i = 0; i < quiet_cycles && done; i++) begin
      next_cycle();
      check_flag("fc2_sent_o", fc2_sent_o, 1'b1);
    end
    if (done) begin
      check_count("beat_count", got_q.size() - base, exp_q.size());
      check_count("init_ack_count", ack_count - ack_base, fc1_rounds);
      for (int i = 0; i < exp_q.size() && base + i < got_q.size(); i++) begin
        compare_beat(got_q[base + i], exp_q[i]);
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_count++;
    if (err_count == err_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d errors", test_count, name, err_count - err_before);
    end
  endtask

  initial begin : main
    int e;
    lcg_state    = 32'hb57b;
    err_count    = 0;
    test_count   = 0;
    fail_count   = 0;
    timed_out    = 1'b0;
    tb_rst       = 1'b0;
    start_i      = 1'b0;
    fc1_stored_i = 1'b0;
    fc2_stored_i = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = 3'd0;
    cfg_wdata_i  = 16'h0000;
    m_tready_i   = 1'b1;

    e = err_count;
    do_reset();
    run_sequence(1, 1, 1'b0, 1'b0);
    end_test("reset_defaults", e);

    e = err_count;
    do_reset();
    randomize_credits();
    run_sequence(1, 1, 1'b0, 1'b0);
    end_test("random_credits", e);

    e = err_count;
    do_reset();
    randomize_credits();
    run_sequence(1, 1, 1'b0, 1'b1);
    end_test("write_while_busy", e);

    e = err_count;
    do_reset();
    randomize_credits();
    run_sequence(2, 1, 1'b0, 1'b0);
    end_test("fc1_retry", e);

    e = err_count;
    do_reset();
    randomize_credits();
    run_sequence(1, 2, 1'b0, 1'b0);
    end_test("fc2_retry", e);

    e = err_count;
    for (int i = 0; i < 3; i++) begin
      do_reset();
      randomize_credits();
      run_sequence(1 + i % 2, 1 + i / 2, 1'b1, 1'b0);
    end
    end_test("backpressure", e);

    $display("tests run %0d, tests failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
// testbench clock source with a 100 ns period and a power-on reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // held over four rising edges
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- filelist.f
+incdir+logic
logic/fc_init_pkg.sv
logic/dllp_crc16.sv
logic/fc_cfg_regs.sv
logic/fc_init_ctrl.sv
logic/axis_skid_buffer.sv
logic/fc_init_top.sv
dv/tb_clk_gen.sv
dv/fc_init_props.sv
dv/fc_init_tb.sv

//--- logic/axis_skid_buffer.sv
// two entry stream register slice with a registered ready toward the source
`timescale 1ns/1ps

module axis_skid_buffer (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  fc_init_pkg::axis_beat_t s_beat_i,
  input  logic                    s_valid_i,
  output logic                    s_ready_o,
  output fc_init_pkg::axis_beat_t m_beat_o,
  output logic                    m_valid_o,
  input  logic                    m_ready_i
);
  import fc_init_pkg::*;

  axis_beat_t main_q;
  axis_beat_t skid_q;
  logic       main_valid_q;
  logic       skid_valid_q;
  logic       s_xfer;
  logic       main_free;

  // accept as long as the skid slot is empty
  assign s_ready_o = !skid_valid_q;
  assign s_xfer    = s_valid_i && s_ready_o;
  assign main_free = !main_valid_q || m_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      // skid entry is older, so it drains first
      main_valid_q <= skid_valid_q || s_xfer;
      skid_valid_q <= 1'b0;
    end else if (s_xfer) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_free) begin
      main_q <= skid_valid_q ? skid_q : s_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!main_free && s_xfer) begin
      skid_q <= s_beat_i;
    end
  end

  assign m_beat_o  = main_q;
  assign m_valid_o = main_valid_q;

endmodule

//--- logic/dllp_crc16.sv
// DLLP CRC16 over one InitFC body, returned in transmit bit order
`timescale 1ns/1ps

module dllp_crc16 (
  input  fc_init_pkg::dllp_fc_t  body_i,
  output fc_init_pkg::dllp_crc_t crc_o
);
  import fc_init_pkg::*;

  localparam dllp_crc_t crc_poly = 16'h100B;
  localparam dllp_crc_t crc_seed = 16'hFFFF;

  dllp_crc_t crc_final;

  // type byte first, msb of each byte first
  always_comb begin : crc_calc
    logic [31:0] data;
    dllp_crc_t   crc;
    logic        fb;
    data = body_i;
    crc  = crc_seed;
    for (int i = 31; i >= 0; i--) begin
      fb  = crc[15] ^ data[i];
      crc = {crc[14:0], 1'b0};
      if (fb) begin
        crc = crc ^ crc_poly;
      end
    end
    crc_final = ~crc;
  end

  // bits go out lsb first within each byte
  always_comb begin : byte_reverse
    for (int i = 0; i < 8; i++) begin
      crc_o[i]     = crc_final[7-i];
      crc_o[i+8]   = crc_final[15-i];
    end
  end

endmodule

//--- logic/fc_cfg_regs.sv
// advertised credit and wait period registers, locked while FC init is running
`timescale 1ns/1ps
`include "fc_init_defines.svh"

module fc_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cfg_we_i,
  input  logic [2:0]           cfg_addr_i,
  input  logic [15:0]          cfg_wdata_i,
  input  logic                 busy_i,
  output fc_init_pkg::fc_cfg_t cfg_o
);
  import fc_init_pkg::*;

  localparam fc_credit_set_t credit_reset = '{hdr: `FC_HDR_RESET, data: `FC_DATA_RESET};

  fc_cfg_t cfg_q;
  logic    wr_en;

  // a running sequence must advertise one consistent set
  assign wr_en = cfg_we_i && !busy_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q.p           <= credit_reset;
      cfg_q.np          <= credit_reset;
      cfg_q.cpl         <= credit_reset;
      cfg_q.wait_period <= `FC_WAIT_RESET;
    end else if (wr_en) begin
      case (cfg_addr_i)
        3'd0: begin
          cfg_q.p.hdr <= cfg_wdata_i[7:0];
        end
        3'd1: begin
          cfg_q.p.data <= cfg_wdata_i[11:0];
        end
        3'd2: begin
          cfg_q.np.hdr <= cfg_wdata_i[7:0];
        end
        3'd3: begin
          cfg_q.np.data <= cfg_wdata_i[11:0];
        end
        3'd4: begin
          cfg_q.cpl.hdr <= cfg_wdata_i[7:0];
        end
        3'd5: begin
          cfg_q.cpl.data <= cfg_wdata_i[11:0];
        end
        3'd6: begin
          cfg_q.wait_period <= cfg_wdata_i;
        end
        // address 7 is unmapped
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

//--- logic/fc_init_ctrl.sv
// FC init sequencer sending InitFC1 then InitFC2 DLLPs as body and CRC beats
`timescale 1ns/1ps
`include "fc_init_defines.svh"

module fc_init_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic                    fc1_stored_i,
  input  logic                    fc2_stored_i,
  input  fc_init_pkg::fc_cfg_t    cfg_i,
  input  logic                    beat_ready_i,
  input  fc_init_pkg::dllp_crc_t  crc_i,
  output fc_init_pkg::axis_beat_t beat_o,
  output logic                    beat_valid_o,
  output fc_init_pkg::dllp_fc_t   body_o,
  output logic                    busy_o,
  output logic                    init_ack_o,
  output logic                    fc2_sent_o
);
  import fc_init_pkg::*;

  fc_state_e      state_q;
  fc_state_e      state_d;
  logic [1:0]     idx_q;
  logic [1:0]     idx_d;
  wait_cnt_t      cnt_q;
  wait_cnt_t      cnt_d;
  dllp_crc_t      crc_q;
  logic           phase_fc2;
  logic           send_body;
  logic           send_crc;
  logic           wait_done;
  fc_credit_set_t credit_sel;
  dllp_type_e     type_sel;

  assign phase_fc2 = state_q inside {ST_FC2_BODY, ST_FC2_CRC, ST_FC2_GAP, ST_CHECK_FC2};

  // body goes out straight from idle so the first beat costs no extra cycle
  assign init_ack_o = (state_q == ST_IDLE) && start_i;
  assign send_body  = init_ack_o || (state_q inside {ST_FC1_BODY, ST_FC2_BODY});
  assign send_crc   = state_q inside {ST_FC1_CRC, ST_FC2_CRC};

  // idx 0 posted, 1 non-posted, 2 completion
  always_comb begin : body_select
    case (idx_q)
      2'd0: begin
        type_sel   = phase_fc2 ? DLLP_INIT_FC2_P : DLLP_INIT_FC1_P;
        credit_sel = cfg_i.p;
      end
      2'd1: begin
        type_sel   = phase_fc2 ? DLLP_INIT_FC2_NP : DLLP_INIT_FC1_NP;
        credit_sel = cfg_i.np;
      end
      default: begin
        type_sel   = phase_fc2 ? DLLP_INIT_FC2_CPL : DLLP_INIT_FC1_CPL;
        credit_sel = cfg_i.cpl;
      end
    endcase
    body_o.dtype   = type_sel;
    body_o.rsvd_hi = 2'b00;
    body_o.hdr     = credit_sel.hdr;
    body_o.rsvd_lo = 2'b00;
    body_o.data    = credit_sel.data;
  end

  // gap and timeout both last wait_period cycles, minimum one
  assign wait_done = wait_cnt_t'(cnt_q + 1'b1) >= cfg_i.wait_period;

  always_comb begin : next_state_logic
    state_d = state_q;
    idx_d   = idx_q;
    cnt_d   = cnt_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = beat_ready_i ? ST_FC1_CRC : ST_FC1_BODY;
        end
      end
      ST_FC1_BODY, ST_FC2_BODY: begin
        if (beat_ready_i) begin
          state_d = phase_fc2 ? ST_FC2_CRC : ST_FC1_CRC;
        end
      end
      ST_FC1_CRC, ST_FC2_CRC: begin
        if (beat_ready_i) begin
          cnt_d = '0;
          if (idx_q == 2'd2) begin
            state_d = phase_fc2 ? ST_CHECK_FC2 : ST_CHECK_FC1;
          end else begin
            state_d = phase_fc2 ? ST_FC2_GAP : ST_FC1_GAP;
          end
        end
      end
      ST_FC1_GAP, ST_FC2_GAP: begin
        cnt_d = cnt_q + 1'b1;
        if (wait_done) begin
          cnt_d   = '0;
          idx_d   = idx_q + 1'b1;
          state_d = phase_fc2 ? ST_FC2_BODY : ST_FC1_BODY;
        end
      end
      ST_CHECK_FC1: begin
        cnt_d = cnt_q + 1'b1;
        if (fc1_stored_i) begin
          cnt_d   = '0;
          idx_d   = '0;
          state_d = ST_FC2_BODY;
        end else if (wait_done) begin
          // partner never answered, start over only if still requested
          cnt_d   = '0;
          idx_d   = '0;
          state_d = ST_IDLE;
        end
      end
      ST_CHECK_FC2: begin
        cnt_d = cnt_q + 1'b1;
        if (fc2_stored_i) begin
          cnt_d   = '0;
          state_d = ST_COMPLETE;
        end else if (wait_done) begin
          cnt_d   = '0;
          idx_d   = '0;
          state_d = ST_FC2_BODY;
        end
      end
      // complete holds until reset
      default: begin
        state_d = state_q;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      cnt_q   <= cnt_d;
    end
  end

  // CRC of the body just sent, replayed as the trailing beat
  always_ff @(posedge clk_i) begin
    if (send_body && beat_ready_i) begin
      crc_q <= crc_i;
    end
  end

  assign beat_valid_o = send_body || send_crc;
  assign beat_o.tdata = send_crc ? `FC_DATA_WIDTH'(crc_q) : body_o;
  assign beat_o.tkeep = send_crc ? 4'h3 : 4'hF;
  assign beat_o.tlast = send_crc;

  assign busy_o     = init_ack_o || !(state_q inside {ST_IDLE, ST_COMPLETE});
  assign fc2_sent_o = state_q == ST_COMPLETE;

endmodule

//--- logic/fc_init_defines.svh
// flow control init macros for stream widths and configuration reset values
`ifndef FC_INIT_DEFINES_SVH
`define FC_INIT_DEFINES_SVH

// output stream data width in bits
`define FC_DATA_WIDTH 32

// one keep bit per data byte
`define FC_KEEP_WIDTH 4

// cycles between DLLPs and before a check timeout
`define FC_WAIT_RESET 16'd160

// minimum advertised header credit
`define FC_HDR_RESET 8'h10

// minimum advertised data credit, 256 byte payload in 16 byte units
`define FC_DATA_RESET 12'h010

`endif

//--- logic/fc_init_pkg.sv
// flow control init types for credits, DLLP layout, controller states and stream beats
`include "fc_init_defines.svh"

package fc_init_pkg;

  typedef logic [7:0]  hdr_credit_t;
  typedef logic [11:0] data_credit_t;
  typedef logic [15:0] wait_cnt_t;
  typedef logic [15:0] dllp_crc_t;

  // VC0 only, so the low nibble of each code stays zero
  typedef enum logic [7:0] {
    DLLP_INIT_FC1_P   = 8'h40,
    DLLP_INIT_FC1_NP  = 8'h50,
    DLLP_INIT_FC1_CPL = 8'h60,
    DLLP_INIT_FC2_P   = 8'hC0,
    DLLP_INIT_FC2_NP  = 8'hD0,
    DLLP_INIT_FC2_CPL = 8'hE0
  } dllp_type_e;

  // body of an InitFC DLLP, first transmitted byte on top
  typedef struct packed {
    dllp_type_e   dtype;
    logic [1:0]   rsvd_hi;
    hdr_credit_t  hdr;
    logic [1:0]   rsvd_lo;
    data_credit_t data;
  } dllp_fc_t;

  typedef struct packed {
    hdr_credit_t  hdr;
    data_credit_t data;
  } fc_credit_set_t;

  typedef struct packed {
    fc_credit_set_t p;
    fc_credit_set_t np;
    fc_credit_set_t cpl;
    wait_cnt_t      wait_period;
  } fc_cfg_t;

  typedef struct packed {
    logic [`FC_DATA_WIDTH-1:0] tdata;
    logic [`FC_KEEP_WIDTH-1:0] tkeep;
    logic                      tlast;
  } axis_beat_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FC1_BODY,
    ST_FC1_CRC,
    ST_FC1_GAP,
    ST_CHECK_FC1,
    ST_FC2_BODY,
    ST_FC2_CRC,
    ST_FC2_GAP,
    ST_CHECK_FC2,
    ST_COMPLETE
  } fc_state_e;

endpackage

//--- logic/fc_init_top.sv
// VC0 flow control init transmitter with config registers and output skid buffer
`timescale 1ns/1ps

module fc_init_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic                    fc1_stored_i,
  input  logic                    fc2_stored_i,
  input  logic                    cfg_we_i,
  input  logic [2:0]              cfg_addr_i,
  input  logic [15:0]             cfg_wdata_i,
  input  logic                    m_tready_i,
  output fc_init_pkg::axis_beat_t m_beat_o,
  output logic                    m_tvalid_o,
  output logic                    init_ack_o,
  output logic                    fc2_sent_o
);
  import fc_init_pkg::*;

  fc_cfg_t    cfg;
  logic       busy;
  axis_beat_t beat;
  logic       beat_valid;
  logic       beat_ready;
  dllp_fc_t   body;
  dllp_crc_t  crc;

  fc_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .busy_i      (busy),
    .cfg_o       (cfg)
  );

  fc_init_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .fc1_stored_i (fc1_stored_i),
    .fc2_stored_i (fc2_stored_i),
    .cfg_i        (cfg),
    .beat_ready_i (beat_ready),
    .crc_i        (crc),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .body_o       (body),
    .busy_o       (busy),
    .init_ack_o   (init_ack_o),
    .fc2_sent_o   (fc2_sent_o)
  );

  dllp_crc16 u_crc (
    .body_i (body),
    .crc_o  (crc)
  );

  axis_skid_buffer u_skid (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_beat_i  (beat),
    .s_valid_i (beat_valid),
    .s_ready_o (beat_ready),
    .m_beat_o  (m_beat_o),
    .m_valid_o (m_tvalid_o),
    .m_ready_i (m_tready_i)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the flow control init testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f filelist.f --top-module fc_init_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vfc_init_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
